//--- verilog/dbg_uart_pkg.sv
package dbg_uart_pkg;

    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;

    // index printed as two hex digits
    localparam int IDX_W = 8;

    // idx(2) + value(4) + lf + cr
    localparam int LINE_CHARS = 8;

    typedef logic [WORD_W-1:0] dbg_word_t;
    typedef logic [BYTE_W-1:0] uart_byte_t;

    localparam uart_byte_t ASCII_LF = 8'h0a;
    localparam uart_byte_t ASCII_CR = 8'h0d;

    // upper case hex digit
    function automatic uart_byte_t hex_ascii(input logic [3:0] nibble);
        uart_byte_t code;
        if (nibble < 4'd10) begin
            code = 8'h30 + {4'h0, nibble};
        end else begin
            code = 8'h37 + {4'h0, nibble}; // 'A' is 0x41
        end
        return code;
    endfunction

endpackage

//--- verilog/dbg_start_gen.sv
module dbg_start_gen #(
    parameter int unsigned FIXED_INTERVAL = 0
) (
    input  logic clk,
    input  logic resetn,
    input  logic trigger_i,
    output logic frame_start_o
);

    generate
        if (FIXED_INTERVAL == 0) begin : g_trigger
            // external trigger, one register stage
            always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                    frame_start_o <= 1'b0;
                end else begin
                    frame_start_o <= trigger_i;
                end
            end
        end else begin : g_interval
            logic [15:0] interval_cnt;

            // period is FIXED_INTERVAL+1 cycles
            always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                    interval_cnt  <= 16'd0;
                    frame_start_o <= 1'b0;
                end else if (interval_cnt == 16'(FIXED_INTERVAL)) begin
                    interval_cnt  <= 16'd0;
                    frame_start_o <= 1'b1;
                end else begin
                    interval_cnt  <= interval_cnt + 16'd1;
                    frame_start_o <= 1'b0;
                end
            end
        end
    endgenerate

endmodule

//--- verilog/dbg_line_formatter.sv
module dbg_line_formatter #(
    parameter int NUM_WORDS = 19
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  logic                                     frame_start_i,
    input  dbg_uart_pkg::dbg_word_t [NUM_WORDS-1:0]  debug_words_i,
    output logic                                     byte_valid_o,
    output dbg_uart_pkg::uart_byte_t                 byte_data_o,
    input  logic                                     byte_ready_i,
    output logic                                     busy_o,
    output logic                                     frame_done_o
);

    localparam int IDX_W  = dbg_uart_pkg::IDX_W;
    localparam int CHAR_W = $clog2(dbg_uart_pkg::LINE_CHARS);
    localparam int SEL_W  = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

    localparam logic [IDX_W-1:0]  LAST_WORD = IDX_W'(NUM_WORDS - 1);
    localparam logic [CHAR_W-1:0] LAST_CHAR = CHAR_W'(dbg_uart_pkg::LINE_CHARS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRESENT,
        ST_ADVANCE,
        ST_DONE
    } state_t;

    state_t                                 state;
    logic [IDX_W-1:0]                       word_idx;
    logic [CHAR_W-1:0]                      char_idx;
    dbg_uart_pkg::dbg_word_t [NUM_WORDS-1:0] snapshot;
    dbg_uart_pkg::dbg_word_t                cur_word;
    logic                                   accept;
    logic                                   xfer;
    logic                                   last_char;

    assign accept    = (state == ST_IDLE) && frame_start_i;
    assign xfer      = byte_valid_o && byte_ready_i;
    assign last_char = (word_idx == LAST_WORD) && (char_idx == LAST_CHAR);

    assign byte_valid_o = (state == ST_PRESENT);

    // frozen copy for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            snapshot <= debug_words_i;
        end
    end

    assign cur_word = snapshot[word_idx[SEL_W-1:0]];

    // character mux, stable while indices hold
    always_comb begin
        case (char_idx)
            3'd0:    byte_data_o = dbg_uart_pkg::hex_ascii(word_idx[7:4]);
            3'd1:    byte_data_o = dbg_uart_pkg::hex_ascii(word_idx[3:0]);
            3'd2:    byte_data_o = dbg_uart_pkg::hex_ascii(cur_word[15:12]);
            3'd3:    byte_data_o = dbg_uart_pkg::hex_ascii(cur_word[11:8]);
            3'd4:    byte_data_o = dbg_uart_pkg::hex_ascii(cur_word[7:4]);
            3'd5:    byte_data_o = dbg_uart_pkg::hex_ascii(cur_word[3:0]);
            3'd6:    byte_data_o = dbg_uart_pkg::ASCII_LF;
            default: byte_data_o = dbg_uart_pkg::ASCII_CR;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state        <= ST_IDLE;
            word_idx     <= '0;
            char_idx     <= '0;
            busy_o       <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state    <= ST_PRESENT;
                        word_idx <= '0;
                        char_idx <= '0;
                        busy_o   <= 1'b1;
                    end
                end
                ST_PRESENT: begin
                    // hold byte and indices until the serializer takes it
                    if (xfer) begin
                        state <= last_char ? ST_DONE : ST_ADVANCE;
                    end
                end
                ST_ADVANCE: begin
                    state <= ST_PRESENT;
                    if (char_idx == LAST_CHAR) begin
                        char_idx <= '0;
                        word_idx <= word_idx + 1'b1; // next line
                    end else begin
                        char_idx <= char_idx + 1'b1;
                    end
                end
                ST_DONE: begin
                    state        <= ST_IDLE;
                    busy_o       <= 1'b0;
                    frame_done_o <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/uart_tx_serializer.sv
module uart_tx_serializer #(
    parameter int CLKS_PER_BIT = 330
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     byte_valid_i,
    input  dbg_uart_pkg::uart_byte_t byte_data_i,
    output logic                     byte_ready_o,
    output logic                     sout_o
);

    localparam int CNT_W   = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int FRAME_W = dbg_uart_pkg::BYTE_W + 2; // start + data + stop

    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    logic [FRAME_W-1:0] shift_q;
    logic [CNT_W-1:0]   baud_cnt;
    logic [3:0]         bits_left;
    logic               xfer;

    assign byte_ready_o = (bits_left == 4'd0);
    assign xfer         = byte_valid_i && byte_ready_o;
    assign sout_o       = shift_q[0];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            shift_q   <= '1; // line idles high
            baud_cnt  <= '0;
            bits_left <= 4'd0;
        end else if (xfer) begin
            // lsb first, start bit in position 0
            shift_q   <= {1'b1, byte_data_i, 1'b0};
            baud_cnt  <= '0;
            bits_left <= 4'(FRAME_W);
        end else if (!byte_ready_o) begin
            if (baud_cnt == BIT_END) begin
                baud_cnt  <= '0;
                shift_q   <= {1'b1, shift_q[FRAME_W-1:1]};
                bits_left <= bits_left - 4'd1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/dbg_uart_top.sv
module dbg_uart_top #(
    parameter int          NUM_WORDS      = 19,
    parameter int          CLKS_PER_BIT   = 330,
    parameter int unsigned FIXED_INTERVAL = 0
) (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    trigger_i,
    input  dbg_uart_pkg::dbg_word_t [NUM_WORDS-1:0] debug_words_i,
    output logic                                    sout_o,
    output logic                                    busy_o,
    output logic                                    frame_done_o
);

    logic                     frame_start;
    logic                     byte_valid;
    logic                     byte_ready;
    dbg_uart_pkg::uart_byte_t byte_data;

    dbg_start_gen #(
        .FIXED_INTERVAL(FIXED_INTERVAL)
    ) dbg_start_gen_inst (
        .clk          (clk),
        .resetn       (resetn),
        .trigger_i    (trigger_i),
        .frame_start_o(frame_start)
    );

    dbg_line_formatter #(
        .NUM_WORDS(NUM_WORDS)
    ) dbg_line_formatter_inst (
        .clk          (clk),
        .resetn       (resetn),
        .frame_start_i(frame_start),
        .debug_words_i(debug_words_i),
        .byte_valid_o (byte_valid),
        .byte_data_o  (byte_data),
        .byte_ready_i (byte_ready),
        .busy_o       (busy_o),
        .frame_done_o (frame_done_o)
    );

    uart_tx_serializer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_serializer_inst (
        .clk         (clk),
        .resetn      (resetn),
        .byte_valid_i(byte_valid),
        .byte_data_i (byte_data),
        .byte_ready_o(byte_ready),
        .sout_o      (sout_o)
    );

endmodule

//--- verification/dbg_uart_checker.sv
module dbg_uart_checker #(
    parameter bit LINE_SIDE = 1'b0  // set when bound into the serializer
) (
    input logic                     clk,
    input logic                     resetn,
    input logic                     valid_i,
    input logic                     ready_i,
    input dbg_uart_pkg::uart_byte_t data_i,
    input logic                     line_i,
    input logic                     busy_i,
    input logic                     done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // byte and valid held until the serializer takes them
    handshake_hold: assert property (@(posedge clk) disable iff (!resetn)
        valid_i && !ready_i |=> valid_i && $stable(data_i))
        else $error("byte handshake dropped or changed before ready");

    if (LINE_SIDE) begin : g_line
        line_idle: assert property (@(posedge clk) disable iff (!resetn)
            ready_i |-> line_i)  // serializer idle means line high
            else $error("serial line low while serializer ready");
    end else begin : g_frame
        done_single: assert property (@(posedge clk) disable iff (!resetn)
            done_i |=> !done_i)
            else $error("frame done pulse longer than one cycle");

        reset_quiet: assert property (@(posedge clk)
            !resetn |-> !busy_i && !done_i)
            else $error("busy or frame done high during reset");
    end

endmodule

bind dbg_line_formatter dbg_uart_checker #(
    .LINE_SIDE(1'b0)
) formatter_chk (
    .clk    (clk),
    .resetn (resetn),
    .valid_i(byte_valid_o),
    .ready_i(byte_ready_i),
    .data_i (byte_data_o),
    .line_i (1'b1),
    .busy_i (busy_o),
    .done_i (frame_done_o)
);

bind uart_tx_serializer dbg_uart_checker #(
    .LINE_SIDE(1'b1)
) serializer_chk (
    .clk    (clk),
    .resetn (resetn),
    .valid_i(byte_valid_i),
    .ready_i(byte_ready_o),
    .data_i (byte_data_i),
    .line_i (sout_o),
    .busy_i (1'b0),
    .done_i (1'b0)
);

//--- verification/dbg_uart_tb.sv
module dbg_uart_tb #(
    parameter int          NUM_WORDS      = 4,
    parameter int          CLKS_PER_BIT   = 4,
    parameter int unsigned FIXED_INTERVAL = 0
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SETS      = 4;
    localparam int LINE_CHARS    = dbg_uart_pkg::LINE_CHARS;
    localparam int START_TIMEOUT = FIXED_INTERVAL + 20 * CLKS_PER_BIT;
    localparam int LATENCY       = 3;  // trigger to start bit
    localparam int IDLE_CYCLES   = 20 * CLKS_PER_BIT;

    logic                                    clk;
    logic                                    resetn;
    logic                                    trigger_i;
    dbg_uart_pkg::dbg_word_t [NUM_WORDS-1:0] debug_words_i;
    logic                                    sout_o;
    logic                                    busy_o;
    logic                                    frame_done_o;

    dbg_uart_pkg::dbg_word_t [NUM_WORDS-1:0] word_sets [NUM_SETS];
    integer seed = 32'hbe95a4fa;
    int     value_errors = 0;
    int     other_errors = 0;
    int     done_count = 0;
    int     frames_checked = 0;
    bit     stop_run = 1'b0;
    logic   busy_prev = 1'b0;

    dbg_uart_top #(
        .NUM_WORDS     (NUM_WORDS),
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .FIXED_INTERVAL(FIXED_INTERVAL)
    ) dbg_uart_top_inst (
        .clk          (clk),
        .resetn       (resetn),
        .trigger_i    (trigger_i),
        .debug_words_i(debug_words_i),
        .sout_o       (sout_o),
        .busy_o       (busy_o),
        .frame_done_o (frame_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_byte(input string name, input dbg_uart_pkg::uart_byte_t got,
                              input dbg_uart_pkg::uart_byte_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // busy must fall on the edge that raises frame done
    always @(negedge clk) begin
        if (resetn && frame_done_o) begin
            done_count++;
            check_flag("busy_o at frame_done_o", busy_o, 1'b0);
            check_flag("busy_o before frame_done_o", busy_prev, 1'b1);
        end
        busy_prev = busy_o;
    end

    function automatic dbg_uart_pkg::uart_byte_t expected_char(
        input dbg_uart_pkg::dbg_word_t value, input int word, input int pos);
        logic [dbg_uart_pkg::IDX_W-1:0] idx;
        logic [3:0]                     nib;
        idx = word[dbg_uart_pkg::IDX_W-1:0];
        if (pos == LINE_CHARS - 2) begin
            return dbg_uart_pkg::ASCII_LF;
        end
        if (pos == LINE_CHARS - 1) begin
            return dbg_uart_pkg::ASCII_CR;
        end
        if (pos < 2) begin
            nib = 4'(idx >> (4 * (1 - pos)));  // index digits, msd first
        end else begin
            nib = 4'(value >> (4 * (5 - pos)));
        end
        return dbg_uart_pkg::hex_ascii(nib);
    endfunction

    // mid-bit sampling on falling edges
    task automatic recv_byte(output dbg_uart_pkg::uart_byte_t data, output int waited);
        bit found;
        int i;
        found  = 1'b0;
        waited = 0;
        data   = '0;
        while (!found && waited < START_TIMEOUT) begin
            @(negedge clk);
            if (sout_o === 1'b0) begin
                found = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!found) begin
            $display("timeout: no start bit on sout_o within %0d cycles", START_TIMEOUT);
            other_errors++;
            stop_run = 1'b1;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (sout_o !== 1'b0) begin
                $display("framing error: start bit on sout_o ended early");
                other_errors++;
            end
            for (i = 0; i < dbg_uart_pkg::BYTE_W; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = sout_o;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (sout_o !== 1'b1) begin
                $display("framing error: stop bit on sout_o is not high");
                other_errors++;
            end
        end
    endtask

    task automatic run_frame(input int set, input bit disturb);
        dbg_uart_pkg::uart_byte_t got;
        int                       waited;
        int                       w;
        int                       c;
        for (w = 0; w < NUM_WORDS && !stop_run; w++) begin
            for (c = 0; c < LINE_CHARS && !stop_run; c++) begin
                recv_byte(got, waited);
                if (!stop_run) begin
                    if (w == 0 && c == 0 && FIXED_INTERVAL == 0) begin
                        check_count("start bit latency", waited, LATENCY);
                    end
                    check_byte($sformatf("sout_o line %0d char %0d", w, c), got,
                               expected_char(word_sets[set][w], w, c));
                end
                if (disturb && w == 0 && c == LINE_CHARS - 1) begin
                    // new inputs mid frame and a trigger that must be ignored
                    @(posedge clk);
                    #5;
                    debug_words_i = word_sets[(set + 1) % NUM_SETS];
                    trigger_i     = 1'b1;
                    @(posedge clk);
                    #5;
                    trigger_i = 1'b0;
                end
            end
        end
        if (!stop_run) begin
            frames_checked++;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("sout_o between frames", sout_o, 1'b1);
            check_flag("busy_o between frames", busy_o, 1'b0);
        end
    endtask

    initial begin
        int s;
        int w;
        resetn    = 1'b1;
        trigger_i = 1'b0;
        for (w = 0; w < NUM_WORDS; w++) begin
            word_sets[0][w] = 16'h0000;
            word_sets[1][w] = 16'hffff;
            word_sets[2][w] = 16'h0001 << (w % 16);  // walking one
            word_sets[3][w] = 16'($random(seed));
        end
        debug_words_i = word_sets[0];
        #1;
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        resetn = 1'b1;
        @(negedge clk);
        check_flag("sout_o after reset", sout_o, 1'b1);
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("frame_done_o after reset", frame_done_o, 1'b0);

        for (s = 0; s < NUM_SETS && !stop_run; s++) begin
            if (FIXED_INTERVAL == 0) begin
                @(posedge clk);
                #5;
                debug_words_i = word_sets[s];
                @(posedge clk);
                #5;
                trigger_i = 1'b1;
                fork
                    begin
                        @(posedge clk);
                        #5;
                        trigger_i = 1'b0;
                    end
                join_none
                run_frame(s, 1'b1);
            end else begin
                run_frame(s, 1'b0);
            end
            if (!stop_run) begin
                check_idle(IDLE_CYCLES);
                check_count("frame_done_o pulses", done_count, s + 1);
                if (FIXED_INTERVAL != 0) begin
                    @(posedge clk);
                    #5;
                    debug_words_i = word_sets[(s + 1) % NUM_SETS];  // before next start
                end
            end
        end

        $display("summary: %0d frames checked, %0d value errors, %0d other errors",
                 frames_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && frames_checked == NUM_SETS) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/dbg_uart_pkg.sv
verilog/dbg_start_gen.sv
verilog/dbg_line_formatter.sv
verilog/uart_tx_serializer.sv
verilog/dbg_uart_top.sv
verification/dbg_uart_checker.sv
verification/dbg_uart_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := dbg_uart_tb
FLIST     := flist.f
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed
# interval run needs a period longer than one frame
INTERVAL  := 1999

.PHONY: help test run_trigger run_interval clean

help:
	@echo "make test          build and run trigger mode and interval mode"
	@echo "make run_trigger   trigger mode only"
	@echo "make run_interval  interval mode only"
	@echo "make clean         remove build directories and logs"

test: run_trigger run_interval

run_trigger:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir obj_trigger -o sim_trigger
	-./obj_trigger/sim_trigger > trigger.log 2>&1
	@if grep -q "$(FAIL_MSG)" trigger.log || ! grep -q "$(PASS_MSG)" trigger.log; then \
		echo "trigger mode FAILED, see trigger.log"; exit 1; \
	else \
		echo "trigger mode passed"; \
	fi

run_interval:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GFIXED_INTERVAL=$(INTERVAL) -f $(FLIST) \
		--Mdir obj_interval -o sim_interval
	-./obj_interval/sim_interval > interval.log 2>&1
	@if grep -q "$(FAIL_MSG)" interval.log || ! grep -q "$(PASS_MSG)" interval.log; then \
		echo "interval mode FAILED, see interval.log"; exit 1; \
	else \
		echo "interval mode passed"; \
	fi

clean:
	rm -rf obj_trigger obj_interval trigger.log interval.log
